// File: Bender.yml
package:
  name: windowClassifier

sources:
  # packages first, then the design bottom-up
  - common/nnFormatPkg.sv
  - common/nnNetworkPkg.sv
  - design/sampleWindow.sv
  - neuronLayer/neuronNode.sv
  - neuronLayer/neuronLayer.sv
  - design/classSelect.sv
  - design/windowClassifier.sv

  # testbench
  - target: simulation
    files:
      - dv/windowClassifierTb.sv

// File: common/nnFormatPkg.sv
package nnFormatPkg;

	// ----------------------------------------
	// datapath widths
	// ----------------------------------------
	localparam int SAMPLE_W = 8;
	localparam int WEIGHT_W = 8;
	localparam int PRODUCT_W = SAMPLE_W + WEIGHT_W;
	localparam int BIAS_W = PRODUCT_W;	// bias is in product scale
	localparam int ACC_W = 23;	// fifteen products plus bias, with headroom
	localparam int ACT_W = 8;

	// ----------------------------------------
	// value types
	// ----------------------------------------
	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [WEIGHT_W-1:0] weight_t;
	typedef logic signed [PRODUCT_W-1:0] product_t;
	typedef logic signed [BIAS_W-1:0] bias_t;
	typedef logic signed [ACC_W-1:0] acc_t;
	typedef logic [ACT_W-1:0] act_t;	// 0 .. ACT_MAX

	// ----------------------------------------
	// output scaling
	// ----------------------------------------
	localparam int FRAC_BITS = 6;	// accumulator bits dropped at the output
	localparam int ACT_MAX = 127;	// clip level after rounding

endpackage

// File: common/nnNetworkPkg.sv
package nnNetworkPkg;

	// ----------------------------------------
	// network shape
	// ----------------------------------------
	localparam int TAPS = 15;	// window length, inputs per node
	localparam int NODES = 4;

	typedef logic [$clog2(NODES)-1:0] classIdx_t;

	// ----------------------------------------
	// weight table, one row per node
	// ----------------------------------------
	// tap 0 is the newest sample
	localparam nnFormatPkg::weight_t [0:NODES-1][0:TAPS-1] NODE_WEIGHTS = '{
		'{-18,  28, -31, -28,   6,  13,  24,  31,  27,  14,  12,  31, -19,  29,  16},
		'{ 12, -25,   7,  30, -14,  -9,  22, -30,   5, -17,  26,  -8,  19, -21, -11},
		'{ -7,  15,  20, -26,  31,  -4, -22,   9, -13,  25, -29,  18,   3, -16,  27},
		'{ 30,  -3, -12,  17, -28,  21,  -6, -24,  11,   2, -20,  28, -31,   8,  -5}
	};

	// ----------------------------------------
	// bias table, product scale
	// ----------------------------------------
	localparam nnFormatPkg::bias_t [0:NODES-1] NODE_BIAS = '{
		0,
		96,	// +1.5 after scaling
		-64,	// -1.0 after scaling
		40
	};

endpackage

// File: design/classSelect.sv
`timescale 1ns/1ns

module classSelect #(
	parameter int NODES = nnNetworkPkg::NODES
) (
	input logic clk,
	input logic reset,
	input nnFormatPkg::act_t [NODES-1:0] nodeAct,
	output nnNetworkPkg::classIdx_t bestClass,
	output nnFormatPkg::act_t bestScore
);

	nnNetworkPkg::classIdx_t scanIdx;
	nnFormatPkg::act_t scanVal;

	// ----------------------------------------
	// argmax scan
	// ----------------------------------------
	always_comb
	begin
		scanIdx = '0;
		scanVal = nodeAct[0];
		for (int n = 1; n < NODES; n++)
		begin
			if (nodeAct[n] > scanVal)	// strict, lowest index keeps a tie
			begin
				scanIdx = nnNetworkPkg::classIdx_t'(n);
				scanVal = nodeAct[n];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			bestClass <= '0;
			bestScore <= '0;
		end
		else
		begin
			bestClass <= scanIdx;
			bestScore <= scanVal;
		end
	end

endmodule

// File: design/sampleWindow.sv
`timescale 1ns/1ns

module sampleWindow #(
	parameter int TAPS = nnNetworkPkg::TAPS
) (
	input logic clk,
	input logic reset,
	input nnFormatPkg::sample_t sample,
	output nnFormatPkg::sample_t [TAPS-1:0] taps
);

	// ----------------------------------------
	// sliding window, tap 0 newest
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			taps <= '0;
		end
		else
		begin
			taps[0] <= sample;	// new value enters at the front
			for (int i = 1; i < TAPS; i++)
			begin
				taps[i] <= taps[i-1];	// oldest falls off the end
			end
		end
	end

endmodule

// File: design/windowClassifier.sv
`timescale 1ns/1ns

module windowClassifier #(
	parameter int TAPS = nnNetworkPkg::TAPS,
	parameter int NODES = nnNetworkPkg::NODES,
	parameter nnFormatPkg::weight_t [0:NODES-1][0:TAPS-1] WEIGHT_TABLE =
		nnNetworkPkg::NODE_WEIGHTS,
	parameter nnFormatPkg::bias_t [0:NODES-1] BIAS_TABLE = nnNetworkPkg::NODE_BIAS
) (
	input logic clk,
	input logic reset,
	input nnFormatPkg::sample_t sample,
	output nnFormatPkg::act_t [NODES-1:0] nodeAct,
	output nnNetworkPkg::classIdx_t bestClass,
	output nnFormatPkg::act_t bestScore
);

	nnFormatPkg::sample_t [TAPS-1:0] taps;

	// ----------------------------------------
	// window -> layer -> argmax
	// ----------------------------------------
	sampleWindow #(
		.TAPS(TAPS)
	) windowInst (
		.clk(clk),
		.reset(reset),
		.sample(sample),
		.taps(taps)
	);

	neuronLayer #(
		.TAPS(TAPS),
		.NODES(NODES),
		.WEIGHT_TABLE(WEIGHT_TABLE),
		.BIAS_TABLE(BIAS_TABLE)
	) layerInst (
		.clk(clk),
		.reset(reset),
		.taps(taps),
		.nodeAct(nodeAct)	// also a top output
	);

	classSelect #(
		.NODES(NODES)
	) selectInst (
		.clk(clk),
		.reset(reset),
		.nodeAct(nodeAct),
		.bestClass(bestClass),
		.bestScore(bestScore)
	);

endmodule

// File: dv/windowClassifierTb.sv
`timescale 1ns/1ns

module windowClassifierTb;

	localparam int TAPS = nnNetworkPkg::TAPS;
	localparam int NODES = nnNetworkPkg::NODES;
	localparam int MAX_CYCLES = 500;	// about 400 cycles of stimulus plus margin

	typedef int window_t[TAPS];

	logic clk;
	logic reset;
	nnFormatPkg::sample_t sample;
	nnFormatPkg::act_t [NODES-1:0] nodeAct;
	nnNetworkPkg::classIdx_t bestClass;
	nnFormatPkg::act_t bestScore;

	// ----------------------------------------
	// model state
	// ----------------------------------------
	nnFormatPkg::sample_t history[$];	// captured samples, newest first
	window_t inWin;	// mirrors the node input register
	int accModel[NODES];
	nnFormatPkg::act_t [NODES-1:0] expAct;
	nnNetworkPkg::classIdx_t expClass;
	nnFormatPkg::act_t expScore;
	logic started;

	int seed;
	int cycles;
	int actErrors;
	int classErrors;
	int scoreErrors;
	int resetErrors;

	windowClassifier #(
		.TAPS(TAPS),
		.NODES(NODES),
		.WEIGHT_TABLE(nnNetworkPkg::NODE_WEIGHTS),
		.BIAS_TABLE(nnNetworkPkg::NODE_BIAS)
	) windowClassifier_inst (
		.clk(clk),
		.reset(reset),
		.sample(sample),
		.nodeAct(nodeAct),
		.bestClass(bestClass),
		.bestScore(bestScore)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#2 clk = ~clk;
		end
	end

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic int nodeSum(input window_t win, input int n);
		int sum;
		sum = int'($signed(nnNetworkPkg::NODE_BIAS[n]));
		for (int i = 0; i < TAPS; i++)
		begin
			sum += win[i] * int'($signed(nnNetworkPkg::NODE_WEIGHTS[n][i]));
		end
		return sum;
	endfunction

	function automatic nnFormatPkg::act_t activate(input int acc);
		int half;
		int whole;
		int rest;
		half = 1 << (nnFormatPkg::FRAC_BITS - 1);
		if (acc < 0)
		begin
			return '0;
		end
		whole = acc / (2 * half);
		rest = acc % (2 * half);
		if (rest > half)	// exact half stays down
		begin
			whole++;
		end
		if (whole > nnFormatPkg::ACT_MAX)
		begin
			whole = nnFormatPkg::ACT_MAX;
		end
		return nnFormatPkg::act_t'(whole);
	endfunction

	function automatic nnNetworkPkg::classIdx_t argmaxIdx(
		input nnFormatPkg::act_t [NODES-1:0] acts
	);
		int best;
		best = 0;
		for (int n = 1; n < NODES; n++)
		begin
			if (acts[n] > acts[best])
			begin
				best = n;
			end
		end
		return nnNetworkPkg::classIdx_t'(best);
	endfunction

	function automatic int tapValue(input int i);
		if (i < history.size())
		begin
			return int'(history[i]);
		end
		return 0;
	endfunction

	// stages updated oldest first so each reads its pre-edge input
	always @(posedge clk)
	begin
		if (reset)
		begin
			history.delete();
			for (int i = 0; i < TAPS; i++)
			begin
				inWin[i] = 0;
			end
			for (int n = 0; n < NODES; n++)
			begin
				accModel[n] = 0;
			end
			expAct = '0;
			expClass = '0;
			expScore = '0;
		end
		else
		begin
			expClass = argmaxIdx(expAct);
			expScore = expAct[expClass];
			for (int n = 0; n < NODES; n++)
			begin
				expAct[n] = activate(accModel[n]);
				accModel[n] = nodeSum(inWin, n);
			end
			for (int i = 0; i < TAPS; i++)
			begin
				inWin[i] = tapValue(i);
			end
			history.push_front(sample);
			if (history.size() > TAPS)
			begin
				void'(history.pop_back());
			end
		end
		started = 1'b1;
	end

	// ----------------------------------------
	// checks
	// ----------------------------------------
	for (genvar n = 0; n < NODES; n++)
	begin : actCheck
		actMatch: assert property (@(posedge clk) !started || nodeAct[n] == expAct[n])
		else
		begin
			actErrors++;
			$display("Error at %0t ns: nodeAct[%0d] expected %0d, got %0d", $time, n,
				$sampled(expAct[n]), $sampled(nodeAct[n]));
		end
	end

	classMatch: assert property (@(posedge clk) !started || bestClass == expClass)
	else
	begin
		classErrors++;
		$display("Error at %0t ns: bestClass expected %0d, got %0d", $time,
			$sampled(expClass), $sampled(bestClass));
	end

	scoreMatch: assert property (@(posedge clk) !started || bestScore == expScore)
	else
	begin
		scoreErrors++;
		$display("Error at %0t ns: bestScore expected %0d, got %0d", $time,
			$sampled(expScore), $sampled(bestScore));
	end

	resetClear: assert property (@(posedge clk)
		(started && $past(reset)) |-> (nodeAct == '0 && bestClass == '0 && bestScore == '0))
	else
	begin
		resetErrors++;
		$display("Error at %0t ns: in reset expected nodeAct 0, bestClass 0, bestScore 0",
			$time);
		$display("Error at %0t ns: in reset got nodeAct %h, bestClass %0d, bestScore %0d",
			$time, $sampled(nodeAct), $sampled(bestClass), $sampled(bestScore));
	end

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	task automatic driveSample(input nnFormatPkg::sample_t value);
		@(negedge clk);
		sample = value;
	endtask

	task automatic holdConstant(input nnFormatPkg::sample_t value, input int count);
		repeat (count)
		begin
			driveSample(value);
		end
	endtask

	task automatic sendImpulse(input nnFormatPkg::sample_t value);
		driveSample(value);
		holdConstant('0, TAPS - 1);	// impulse leaves as the next one enters
	endtask

	// full scale, sign chosen so nodes 0 and 2 both saturate
	task automatic buildTieWindow();
		int mix;
		for (int i = TAPS - 1; i >= 0; i--)
		begin
			mix = int'($signed(nnNetworkPkg::NODE_WEIGHTS[0][i]))
				+ int'($signed(nnNetworkPkg::NODE_WEIGHTS[2][i]));
			if (mix >= 0)
			begin
				driveSample(nnFormatPkg::sample_t'(127));
			end
			else
			begin
				driveSample(nnFormatPkg::sample_t'(-127));
			end
		end
	endtask

	task automatic runRandom(input int count);
		repeat (count)
		begin
			driveSample(nnFormatPkg::sample_t'($random(seed)));
		end
	endtask

	initial
	begin
		seed = 1;
		actErrors = 0;
		classErrors = 0;
		scoreErrors = 0;
		resetErrors = 0;
		started = 1'b0;
		reset = 1'b1;
		sample = '0;
		repeat (3) @(negedge clk);
		reset = 1'b0;

		holdConstant('0, TAPS + 1);	// bias only, nodes 1 and 3 tie
		sendImpulse(16);	// node 1 sum 288, exact half
		sendImpulse(17);	// node 1 sum 300, above half
		holdConstant(-128, TAPS);	// node 0 negative
		holdConstant(127, TAPS);	// node 0 clips at 127
		buildTieWindow();
		runRandom(300);
		holdConstant('0, 6);	// drain the pipeline
		@(negedge clk);

		$display("errors: nodeAct %0d, bestClass %0d, bestScore %0d, reset %0d",
			actErrors, classErrors, scoreErrors, resetErrors);
		if (actErrors + classErrors + scoreErrors + resetErrors == 0)
		begin
			$display("Everything OK");
		end
		else
		begin
			$display("Something failed");
		end
		$finish;
	end

	initial
	begin
		cycles = 0;
		while (cycles < MAX_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not end within %0d cycles", MAX_CYCLES);
		$display("Something failed");
		$finish;
	end

endmodule

// File: neuronLayer/neuronLayer.sv
`timescale 1ns/1ns

module neuronLayer #(
	parameter int TAPS = nnNetworkPkg::TAPS,
	parameter int NODES = nnNetworkPkg::NODES,
	parameter nnFormatPkg::weight_t [0:NODES-1][0:TAPS-1] WEIGHT_TABLE =
		nnNetworkPkg::NODE_WEIGHTS,
	parameter nnFormatPkg::bias_t [0:NODES-1] BIAS_TABLE = nnNetworkPkg::NODE_BIAS
) (
	input logic clk,
	input logic reset,
	input nnFormatPkg::sample_t [TAPS-1:0] taps,
	output nnFormatPkg::act_t [NODES-1:0] nodeAct
);

	// ----------------------------------------
	// one node per table row
	// ----------------------------------------
	for (genvar n = 0; n < NODES; n++)
	begin : genNode
		neuronNode #(
			.TAPS(TAPS),
			.WEIGHTS(WEIGHT_TABLE[n]),	// row n
			.BIAS(BIAS_TABLE[n])
		) nodeInst (
			.clk(clk),
			.reset(reset),
			.inputs(taps),	// whole window shared by all nodes
			.act(nodeAct[n])
		);
	end

endmodule

// File: neuronLayer/neuronNode.sv
`timescale 1ns/1ns

module neuronNode #(
	parameter int TAPS = nnNetworkPkg::TAPS,
	parameter nnFormatPkg::weight_t [0:TAPS-1] WEIGHTS = '0,
	parameter nnFormatPkg::bias_t BIAS = '0
) (
	input logic clk,
	input logic reset,
	input nnFormatPkg::sample_t [TAPS-1:0] inputs,
	output nnFormatPkg::act_t act
);

	nnFormatPkg::sample_t [TAPS-1:0] inputReg;
	nnFormatPkg::product_t [TAPS-1:0] products;
	nnFormatPkg::acc_t accNext;
	nnFormatPkg::acc_t acc;
	nnFormatPkg::acc_t accShift;
	nnFormatPkg::acc_t accRounded;
	logic roundUp;
	nnFormatPkg::act_t actNext;

	// ----------------------------------------
	// multiply-accumulate
	// ----------------------------------------
	always_comb
	begin
		for (int i = 0; i < TAPS; i++)
		begin
			products[i] = $signed(inputReg[i]) * $signed(WEIGHTS[i]);
		end
	end

	always_comb
	begin
		accNext = nnFormatPkg::acc_t'(BIAS);	// sign extended
		for (int i = 0; i < TAPS; i++)
		begin
			accNext = accNext + nnFormatPkg::acc_t'(products[i]);
		end
	end

	// ----------------------------------------
	// rectify, round, clip
	// ----------------------------------------
	always_comb
	begin
		accShift = acc >>> nnFormatPkg::FRAC_BITS;
		// round up only above an exact half
		roundUp = acc[nnFormatPkg::FRAC_BITS-1] & (|acc[nnFormatPkg::FRAC_BITS-2:0]);
		accRounded = accShift + nnFormatPkg::acc_t'(roundUp);
		if (acc[nnFormatPkg::ACC_W-1])
		begin
			actNext = '0;	// negative sum
		end
		else if (accRounded > nnFormatPkg::ACT_MAX)
		begin
			actNext = nnFormatPkg::act_t'(nnFormatPkg::ACT_MAX);
		end
		else
		begin
			actNext = nnFormatPkg::act_t'(accRounded);
		end
	end

	// three register stages: inputs, sum, activation
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inputReg <= '0;
			acc <= '0;
			act <= '0;
		end
		else
		begin
			inputReg <= inputs;
			acc <= accNext;
			act <= actNext;
		end
	end

endmodule

// File: windowClassifier.f
common/nnFormatPkg.sv
common/nnNetworkPkg.sv
design/sampleWindow.sv
neuronLayer/neuronNode.sv
neuronLayer/neuronLayer.sv
design/classSelect.sv
design/windowClassifier.sv
dv/windowClassifierTb.sv
